//--- verilog/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Word geometry

    // Payload bits carried per entry
    localparam int DATA_WIDTH = 16;

    //////////////////////////////////////////////////////////////////////
    // Storage geometry

    // Entries held by each channel
    localparam int FIFO_DEPTH = 8;

    // Index into the storage array
    localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

    // Occupancy needs one more bit to count a full buffer
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

    //////////////////////////////////////////////////////////////////////
    // Flag thresholds

    // Almost full at depth minus this margin or more
    localparam int AF_MARGIN = 2;

    // Almost empty from one entry up to this margin
    localparam int AE_MARGIN = 2;

endpackage : fifo_pkg

`default_nettype wire

//--- verilog/chan_pkg.sv
`default_nettype none

package chan_pkg;

    //////////////////////////////////////////////////////////////////////
    // Channel geometry

    // Independent buffers behind the dispatcher
    localparam int NUM_CHAN = 4;

    // Bits of a channel id on the input and output side
    localparam int CHAN_WIDTH = $clog2(NUM_CHAN);

    //////////////////////////////////////////////////////////////////////
    // Input command opcodes

    // Two-bit opcode qualified by the input strobe
    typedef enum logic [1:0] {
        // Idle slot
        CMD_NOP   = 2'b00,
        // Append data word to channel
        CMD_PUSH  = 2'b01,
        // Drop all words of channel
        CMD_FLUSH = 2'b10,
        // Spare code, decoded as idle
        CMD_RSVD  = 2'b11
    } cmd_e;

endpackage : chan_pkg

`default_nettype wire

//--- verilog/sync_fifo.sv
`default_nettype none

module sync_fifo
    import fifo_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Control from dispatcher
    input  logic                  i_flush,
    input  logic                  i_write,
    input  logic [DATA_WIDTH-1:0] i_wr_data,

    // Pop from drainer
    input  logic                  i_read,
    output logic [DATA_WIDTH-1:0] o_rd_data,

    // Status
    output logic                  o_full,
    output logic                  o_almost_full,
    output logic                  o_empty,
    output logic                  o_almost_empty
);

    //////////////////////////////////////////////////////////////////////
    // Pointers and storage

    // Extended pointers, top bit flips on every wrap
    logic [ADDR_WIDTH:0]   r_wr_ptr;
    logic [ADDR_WIDTH:0]   r_rd_ptr;

    // Addresses into storage
    logic [ADDR_WIDTH-1:0] w_wr_addr;
    logic [ADDR_WIDTH-1:0] w_rd_addr;

    // Wrap parity of the two pointers
    logic                  w_wrap_diff;

    // Words currently held
    logic [COUNT_WIDTH-1:0] w_count;

    // Flop array, no reset on payload
    logic [DATA_WIDTH-1:0] r_mem [FIFO_DEPTH];

    assign w_wr_addr   = r_wr_ptr[ADDR_WIDTH-1:0];
    assign w_rd_addr   = r_rd_ptr[ADDR_WIDTH-1:0];
    assign w_wrap_diff = r_wr_ptr[ADDR_WIDTH] ^ r_rd_ptr[ADDR_WIDTH];

    //////////////////////////////////////////////////////////////////////
    // Write side

    // Flush clears pointers, so a write in the same cycle is lost
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
        end else if (i_flush) begin
            r_wr_ptr <= '0;
        end else if (i_write) begin
            r_wr_ptr <= r_wr_ptr + 1'b1;
        end
    end

    // Storage write
    always_ff @(posedge i_clk) begin
        if (i_write && !i_flush) begin
            r_mem[w_wr_addr] <= i_wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read side

    // Same priority as the write pointer
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_rd_ptr <= '0;
        end else if (i_flush) begin
            r_rd_ptr <= '0;
        end else if (i_read) begin
            r_rd_ptr <= r_rd_ptr + 1'b1;
        end
    end

    // Head entry shown without a register
    assign o_rd_data = r_mem[w_rd_addr];

    //////////////////////////////////////////////////////////////////////
    // Status flags

    // Same address, different wrap means all entries used
    assign o_full  = w_wrap_diff && (w_wr_addr == w_rd_addr);
    assign o_empty = !w_wrap_diff && (w_wr_addr == w_rd_addr);

    // Pointer difference is the occupancy, wrap handled by modulo math
    assign w_count = r_wr_ptr - r_rd_ptr;

    // Upstream throttle point
    assign o_almost_full = (w_count >= COUNT_WIDTH'(FIFO_DEPTH - AF_MARGIN));

    // Low water mark, never raised when nothing is held
    assign o_almost_empty = (w_count != '0) &&
                            (w_count <= COUNT_WIDTH'(AE_MARGIN));

endmodule : sync_fifo

`default_nettype wire

//--- verilog/chan_dispatch.sv
`default_nettype none

module chan_dispatch
    import fifo_pkg::*;
    import chan_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Command input
    input  logic                  i_in_valid,
    input  cmd_e                  i_in_cmd,
    input  logic [CHAN_WIDTH-1:0] i_in_chan,
    input  logic [DATA_WIDTH-1:0] i_in_data,

    // Full flags of all channels
    input  logic [NUM_CHAN-1:0]   i_full,

    // Per-channel strobes
    output logic [NUM_CHAN-1:0]   o_wr,
    output logic [DATA_WIDTH-1:0] o_wr_data,
    output logic [NUM_CHAN-1:0]   o_flush,

    // Rejected push
    output logic                  o_drop
);

    //////////////////////////////////////////////////////////////////////
    // Opcode decode

    logic w_push;
    logic w_flush;
    logic w_chan_full;

    // Valid strobe qualifies the opcode
    always_comb begin
        w_push  = 1'b0;
        w_flush = 1'b0;
        if (i_in_valid) begin
            case (i_in_cmd)
                CMD_PUSH:  w_push  = 1'b1;
                CMD_FLUSH: w_flush = 1'b1;
                // Reserved code behaves as idle
                CMD_NOP, CMD_RSVD: ;
                default: ;
            endcase
        end
    end

    // State of the addressed channel
    assign w_chan_full = i_full[i_in_chan];

    //////////////////////////////////////////////////////////////////////
    // Channel steering

    // One-hot on the addressed channel, push only if room
    assign o_wr    = (w_push && !w_chan_full) ? (NUM_CHAN'(1) << i_in_chan) : '0;
    assign o_flush = w_flush ? (NUM_CHAN'(1) << i_in_chan) : '0;

    // Data bus shared by all channels, o_wr picks the target
    assign o_wr_data = i_in_data;

    //////////////////////////////////////////////////////////////////////
    // Drop pulse

    // One cycle after the rejected push
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_drop <= 1'b0;
        end else begin
            o_drop <= w_push && w_chan_full;
        end
    end

endmodule : chan_dispatch

`default_nettype wire

//--- verilog/rr_drain.sv
`default_nettype none

module rr_drain
    import fifo_pkg::*;
    import chan_pkg::*;
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,

    // Output back-pressure level
    input  logic                                i_out_stall,

    // FIFO heads
    input  logic [NUM_CHAN-1:0]                 i_empty,
    input  logic [NUM_CHAN-1:0][DATA_WIDTH-1:0] i_rd_data,

    // Pop strobes
    output logic [NUM_CHAN-1:0]                 o_rd,

    // Registered output stage
    output logic                                o_out_valid,
    output logic [CHAN_WIDTH-1:0]               o_out_chan,
    output logic [DATA_WIDTH-1:0]               o_out_data
);

    //////////////////////////////////////////////////////////////////////
    // Arbitration state

    // Channel served last
    logic [CHAN_WIDTH-1:0] r_last;

    // Search result
    logic                  w_found;
    logic [CHAN_WIDTH-1:0] w_sel;

    // Pop this cycle
    logic                  w_pop;

    //////////////////////////////////////////////////////////////////////
    // Round-robin search

    // Start one past the last served channel, wrap, take first non-empty
    always_comb begin
        int v_idx;
        v_idx   = 0;
        w_found = 1'b0;
        w_sel   = '0;
        for (int off = 1; off <= NUM_CHAN; off++) begin
            v_idx = (int'(r_last) + off) % NUM_CHAN;
            if (!w_found && !i_empty[v_idx]) begin
                w_found = 1'b1;
                w_sel   = CHAN_WIDTH'(v_idx);
            end
        end
    end

    // Stall holds every word in its FIFO
    assign w_pop = w_found && !i_out_stall;

    assign o_rd = w_pop ? (NUM_CHAN'(1) << w_sel) : '0;

    //////////////////////////////////////////////////////////////////////
    // Pointer and valid

    // Reset to last channel so channel 0 wins first
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_last      <= CHAN_WIDTH'(NUM_CHAN - 1);
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= w_pop;
            if (w_pop) begin
                r_last <= w_sel;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output payload

    // Captured only on a pop
    always_ff @(posedge i_clk) begin
        if (w_pop) begin
            o_out_chan <= w_sel;
            o_out_data <= i_rd_data[w_sel];
        end
    end

endmodule : rr_drain

`default_nettype wire

//--- verilog/chan_buffer_top.sv
`default_nettype none

module chan_buffer_top
    import fifo_pkg::*;
    import chan_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst_n,

    // Command input
    input  logic                  i_in_valid,
    input  cmd_e                  i_in_cmd,
    input  logic [CHAN_WIDTH-1:0] i_in_chan,
    input  logic [DATA_WIDTH-1:0] i_in_data,

    // Output side
    input  logic                  i_out_stall,
    output logic                  o_out_valid,
    output logic [CHAN_WIDTH-1:0] o_out_chan,
    output logic [DATA_WIDTH-1:0] o_out_data,

    // Status toward upstream
    output logic                  o_drop,
    output logic [NUM_CHAN-1:0]   o_full,
    output logic [NUM_CHAN-1:0]   o_almost_full
);

    //////////////////////////////////////////////////////////////////////
    // Internal buses

    // Dispatcher to FIFOs
    logic [NUM_CHAN-1:0]                 w_wr;
    logic [DATA_WIDTH-1:0]               w_wr_data;
    logic [NUM_CHAN-1:0]                 w_flush;

    // FIFOs to drainer and back
    logic [NUM_CHAN-1:0]                 w_empty;
    logic [NUM_CHAN-1:0][DATA_WIDTH-1:0] w_rd_data;
    logic [NUM_CHAN-1:0]                 w_rd;

    //////////////////////////////////////////////////////////////////////
    // Command decode

    chan_dispatch i_chan_dispatch (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_in_valid (i_in_valid),
        .i_in_cmd   (i_in_cmd),
        .i_in_chan  (i_in_chan),
        .i_in_data  (i_in_data),
        .i_full     (o_full),
        .o_wr       (w_wr),
        .o_wr_data  (w_wr_data),
        .o_flush    (w_flush),
        .o_drop     (o_drop)
    );

    //////////////////////////////////////////////////////////////////////
    // Channel buffers

    for (genvar g = 0; g < NUM_CHAN; g++) begin : g_chan
        // Almost empty not needed at this level
        sync_fifo i_sync_fifo (
            .i_clk          (i_clk),
            .i_rst_n        (i_rst_n),
            .i_flush        (w_flush[g]),
            .i_write        (w_wr[g]),
            .i_wr_data      (w_wr_data),
            .i_read         (w_rd[g]),
            .o_rd_data      (w_rd_data[g]),
            .o_full         (o_full[g]),
            .o_almost_full  (o_almost_full[g]),
            .o_empty        (w_empty[g]),
            .o_almost_empty ()
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Output arbitration

    rr_drain i_rr_drain (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_out_stall (i_out_stall),
        .i_empty     (w_empty),
        .i_rd_data   (w_rd_data),
        .o_rd        (w_rd),
        .o_out_valid (o_out_valid),
        .o_out_chan  (o_out_chan),
        .o_out_data  (o_out_data)
    );

endmodule : chan_buffer_top

`default_nettype wire

//--- tb/chan_buffer_assertions.sv
`default_nettype none

module chan_buffer_assertions
    import chan_pkg::*;
(
    input wire logic                i_clk,
    input wire logic                i_rst_n,
    input wire logic                i_out_stall,
    input wire logic                o_out_valid,
    input wire logic                o_drop,
    input wire logic [NUM_CHAN-1:0] o_full,
    input wire logic [NUM_CHAN-1:0] o_almost_full
);

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////
    // Reset behavior

    // Output strobes quiet after any reset edge
    a_reset_quiet : assert property (
        @(posedge i_clk) !i_rst_n |=> (!o_out_valid && !o_drop)
    ) else $error("output strobe active after reset edge");

    //////////////////////////////////////////////////////////////////////
    // Output side

    // Stalled edge pops nothing
    a_stall_no_valid : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_out_stall |=> !o_out_valid
    ) else $error("output valid after stalled edge");

    // Full channel is also almost full
    a_full_almost : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_full & ~o_almost_full) == '0
    ) else $error("full flag without almost-full flag");

endmodule : chan_buffer_assertions

// Attach to every top-level instance
bind chan_buffer_top chan_buffer_assertions i_chan_buffer_assertions (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_out_stall   (i_out_stall),
    .o_out_valid   (o_out_valid),
    .o_drop        (o_drop),
    .o_full        (o_full),
    .o_almost_full (o_almost_full)
);

`default_nettype wire

//--- tb/tb_chan_buffer.sv
`default_nettype none

module tb_chan_buffer
    import fifo_pkg::*;
    import chan_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    //////////////////////////////////////////////////////////////////////
    // DUT signals

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_in_valid;
    cmd_e                  i_in_cmd;
    logic [CHAN_WIDTH-1:0] i_in_chan;
    logic [DATA_WIDTH-1:0] i_in_data;
    logic                  i_out_stall;
    logic                  o_out_valid;
    logic [CHAN_WIDTH-1:0] o_out_chan;
    logic [DATA_WIDTH-1:0] o_out_data;
    logic                  o_drop;
    logic [NUM_CHAN-1:0]   o_full;
    logic [NUM_CHAN-1:0]   o_almost_full;

    chan_buffer_top i_chan_buffer_top (.*);

    // 10 ns period
    always #5 i_clk = ~i_clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model state

    logic [DATA_WIDTH-1:0] mdl_q [NUM_CHAN][$];
    int                    mdl_last;
    logic                  exp_valid;
    logic [CHAN_WIDTH-1:0] exp_chan;
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_drop;
    logic                  checking;
    int                    out_count;
    logic [31:0]           rng;

    //////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_chan(input string name, input logic [CHAN_WIDTH-1:0] got,
                              input logic [CHAN_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flags(input string name, input logic [NUM_CHAN-1:0] got,
                               input logic [NUM_CHAN-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic fail_with(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_on_error();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Random data

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] next_word();
        rng = xorshift(rng);
        return rng[DATA_WIDTH-1:0];
    endfunction

    // Flags the model expects right now
    function automatic logic [NUM_CHAN-1:0] model_full();
        logic [NUM_CHAN-1:0] v;
        for (int c = 0; c < NUM_CHAN; c++) begin
            v[c] = (mdl_q[c].size() == FIFO_DEPTH);
        end
        return v;
    endfunction

    function automatic logic [NUM_CHAN-1:0] model_almost_full();
        logic [NUM_CHAN-1:0] v;
        for (int c = 0; c < NUM_CHAN; c++) begin
            v[c] = (mdl_q[c].size() >= FIFO_DEPTH - AF_MARGIN);
        end
        return v;
    endfunction

    function automatic logic model_empty();
        logic v;
        v = 1'b1;
        for (int c = 0; c < NUM_CHAN; c++) begin
            if (mdl_q[c].size() != 0) begin
                v = 1'b0;
            end
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Model update at each edge, inputs seen before their NBA update

    always @(posedge i_clk) begin : model_step
        int          idx;
        logic        found;
        logic [NUM_CHAN-1:0] full_pre;
        found    = 1'b0;
        full_pre = model_full();
        if (!i_rst_n) begin
            for (int c = 0; c < NUM_CHAN; c++) begin
                mdl_q[c].delete();
            end
            // Channel 0 served first
            mdl_last  = NUM_CHAN - 1;
            exp_valid = 1'b0;
            exp_drop  = 1'b0;
        end else begin
            exp_valid = 1'b0;
            // Search upward from the channel after the last one served
            if (!i_out_stall) begin
                for (int off = 1; off <= NUM_CHAN; off++) begin
                    idx = (mdl_last + off) % NUM_CHAN;
                    if (!found && mdl_q[idx].size() != 0) begin
                        found     = 1'b1;
                        exp_valid = 1'b1;
                        exp_chan  = CHAN_WIDTH'(idx);
                        exp_data  = mdl_q[idx].pop_front();
                        mdl_last  = idx;
                    end
                end
            end
            exp_drop = 1'b0;
            if (i_in_valid && i_in_cmd == CMD_PUSH) begin
                if (full_pre[i_in_chan]) begin
                    exp_drop = 1'b1;
                end else begin
                    mdl_q[i_in_chan].push_back(i_in_data);
                end
            end
            // Flush after the pop, the popped word still leaves
            if (i_in_valid && i_in_cmd == CMD_FLUSH) begin
                mdl_q[i_in_chan].delete();
            end
        end
    end

    // Outputs compared mid-cycle
    always @(negedge i_clk) begin
        if (checking) begin
            check_bit("o_out_valid", o_out_valid, exp_valid);
            // Words actually delivered by the DUT
            if (o_out_valid) begin
                out_count++;
            end
            if (exp_valid) begin
                check_chan("o_out_chan", o_out_chan, exp_chan);
                check_data("o_out_data", o_out_data, exp_data);
            end
            check_bit("o_drop", o_drop, exp_drop);
            check_flags("o_full", o_full, model_full());
            check_flags("o_almost_full", o_almost_full, model_almost_full());
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Drive helpers

    task automatic send_cmd(input cmd_e cmd, input int ch, input logic [DATA_WIDTH-1:0] d);
        @(posedge i_clk);
        i_in_valid <= 1'b1;
        i_in_cmd   <= cmd;
        i_in_chan  <= CHAN_WIDTH'(ch);
        i_in_data  <= d;
    endtask

    task automatic idle();
        @(posedge i_clk);
        i_in_valid <= 1'b0;
        i_in_cmd   <= CMD_NOP;
    endtask

    task automatic set_stall(input logic v);
        @(posedge i_clk);
        i_out_stall <= v;
    endtask

    task automatic push_words(input int ch, input int n);
        for (int i = 0; i < n; i++) begin
            send_cmd(CMD_PUSH, ch, next_word());
        end
        idle();
    endtask

    // Until model and output stage are both empty
    task automatic wait_drained();
        logic done;
        done = 1'b0;
        for (int t = 0; t < 200 && !done; t++) begin
            @(negedge i_clk);
            done = model_empty() && !o_out_valid;
        end
        if (!done) begin
            fail_with("channels did not drain before timeout");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_order();
        int start;
        start = out_count;
        push_words(2, 5);
        wait_drained();
        if (out_count - start != 5) begin
            fail_with("wrong number of words from channel 2");
        end
    endtask

    task automatic test_round_robin();
        int start;
        start = out_count;
        set_stall(1'b1);
        push_words(0, 3);
        push_words(1, 1);
        push_words(3, 2);
        set_stall(1'b0);
        wait_drained();
        if (out_count - start != 6) begin
            fail_with("round robin lost words");
        end
    endtask

    task automatic test_full_drop();
        set_stall(1'b1);
        push_words(1, FIFO_DEPTH);
        @(negedge i_clk);
        check_flags("o_full", o_full, NUM_CHAN'(2));
        // Extra word must be refused
        send_cmd(CMD_PUSH, 1, next_word());
        idle();
        @(negedge i_clk);
        check_bit("o_drop", o_drop, 1'b1);
        set_stall(1'b0);
        wait_drained();
    endtask

    task automatic test_almost_full();
        set_stall(1'b1);
        for (int i = 1; i <= FIFO_DEPTH; i++) begin
            send_cmd(CMD_PUSH, 3, next_word());
            idle();
            @(negedge i_clk);
            check_bit("o_almost_full[3]", o_almost_full[3], i >= FIFO_DEPTH - AF_MARGIN);
        end
        // Falling edge watched by the monitor while draining
        set_stall(1'b0);
        wait_drained();
    endtask

    task automatic test_stall();
        int start;
        start = out_count;
        set_stall(1'b1);
        push_words(0, 2);
        push_words(2, 3);
        // Output stage must stay quiet for the whole window
        for (int t = 0; t < 20; t++) begin
            @(negedge i_clk);
            if (o_out_valid) begin
                fail_with("output appeared while stalled");
            end
        end
        set_stall(1'b0);
        wait_drained();
        if (out_count - start != 5) begin
            fail_with("words lost across stall");
        end
    endtask

    task automatic test_flush();
        set_stall(1'b1);
        push_words(0, FIFO_DEPTH);
        push_words(2, 3);
        send_cmd(CMD_FLUSH, 0, '0);
        idle();
        @(negedge i_clk);
        check_flags("o_full", o_full, '0);
        check_flags("o_almost_full", o_almost_full, '0);
        set_stall(1'b0);
        wait_drained();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        i_clk       = 1'b0;
        i_rst_n     = 1'b0;
        i_in_valid  = 1'b0;
        i_in_cmd    = CMD_NOP;
        i_in_chan   = '0;
        i_in_data   = '0;
        i_out_stall = 1'b0;
        checking    = 1'b0;
        out_count   = 0;
        rng         = 32'hdf9e3867;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(posedge i_clk);
        checking = 1'b1;
        test_order();
        test_round_robin();
        test_full_drop();
        test_almost_full();
        test_stall();
        test_flush();
        repeat (2) @(posedge i_clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

    // Whole-run guard
    initial begin
        #100us;
        fail_with("global simulation timeout");
    end

endmodule : tb_chan_buffer

`default_nettype wire

//--- tb.f
verilog/fifo_pkg.sv
verilog/chan_pkg.sv
verilog/sync_fifo.sv
verilog/chan_dispatch.sv
verilog/rr_drain.sv
verilog/chan_buffer_top.sv
tb/chan_buffer_assertions.sv
tb/tb_chan_buffer.sv

//--- Makefile
# Verilator simulation of the channel buffer

VERILATOR ?= verilator
TOP       ?= tb_chan_buffer
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Verdict comes from the log
run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
